/* colmix.f */
+incdir+logic
logic/video_pkg.sv
logic/cpu_pkg.sv
logic/layer_prio.sv
logic/pal_lookup.sv
logic/blank_out.sv
logic/colmix.sv
dv/colmix_tb.sv

/* dv/colmix_tb.sv */
// ============================================================
// colour mixer testbench
// palette and PROM loading, CPU readback, slot stimulus,
// reference model with slot history and output assertions
// ============================================================
`include "colmix_consts.svh"

module colmix_tb;

    logic clk = 1'b0;
    logic reset;
    logic pxl_cen;
    logic lhbl;
    logic lvbl;
    logic [`COLMIX_PRISEL_W-1:0] prisel;
    video_pkg::pxl_t ba0_pxl;
    video_pkg::pxl_t ba1_pxl;
    video_pkg::pxl_t ba2_pxl;
    video_pkg::pxl_t obj_pxl;
    cpu_pkg::pal_cs_t pal_cs;
    cpu_pkg::cpu_addr_t cpu_addr;
    cpu_pkg::cpu_data_t cpu_dout;
    cpu_pkg::cpu_be_t dsn;
    cpu_pkg::cpu_data_t cpu_din;
    video_pkg::prio_addr_t prog_addr;
    video_pkg::sel_t prom_din;
    logic prom_we;
    video_pkg::col_t red;
    video_pkg::col_t green;
    video_pkg::col_t blue;
    logic lhbl_dly;
    logic lvbl_dly;

    // reference copies of PROM and palette
    video_pkg::sel_t    prom_ref [0:(1 << `COLMIX_PROM_AW)-1];
    cpu_pkg::cpu_data_t gr_ref   [0:(1 << `COLMIX_PAL_AW)-1];
    video_pkg::col_t    b_ref    [0:(1 << `COLMIX_PAL_AW)-1];

    // {lhbl, lvbl, green, red, blue} per slot, hist0 newest
    logic [25:0] hist0;
    logic [25:0] hist1;
    logic [25:0] exp_out;
    logic        check_on;
    logic        rd_chk;
    cpu_pkg::cpu_data_t exp_din;

    integer seed = 32'h3096_1e83;
    integer errors = 0;
    integer checks = 0;
    string  test_name = "reset";

    colmix colmix_inst (.*);

    always #4 clk = ~clk;

    // expected output of one slot, straight from the mixing rules
    function automatic logic [25:0] slot_expect(video_pkg::pxl_t b0, video_pkg::pxl_t b1,
            video_pkg::pxl_t b2, video_pkg::pxl_t ob, logic [2:0] ps, logic lh, logic lv);
        video_pkg::prio_addr_t pa;
        video_pkg::sel_t code;
        video_pkg::pxl_t pix;
        video_pkg::pal_addr_t ca;
        pa = {ps, b0[3:0] == 4'd0, ob[7], ob[3:0] == 4'd0, b1[7], ob[3],
              b1[2:0] == 3'd0, (b2[7] == 1'b0) && (b2[2:0] == 3'd0)};
        code = prom_ref[pa];
        case (code)
            2'd0:    pix = b0;
            2'd1:    pix = ob;
            2'd2:    pix = b1;
            default: pix = b2;
        endcase
        ca = {code, pix};
        if (lh && lv) begin
            return {lh, lv, gr_ref[ca], b_ref[ca]};
        end
        return {lh, lv, 24'h0};
    endfunction

    // model pipeline, a slot shows up two slots later
    always @(posedge clk) begin
        if (reset) begin
            hist0   <= '0;
            hist1   <= '0;
            exp_out <= '0;
        end else if (pxl_cen) begin
            exp_out <= hist1;
            hist1   <= hist0;
            hist0   <= slot_expect(ba0_pxl, ba1_pxl, ba2_pxl, obj_pxl, prisel, lhbl, lvbl);
        end
    end

    out_a : assert property (@(posedge clk) disable iff (reset)
        check_on |-> ({lhbl_dly, lvbl_dly, green, red, blue} == exp_out))
        checks++;
    else begin
        $display("[FAIL] %s expected %h actual %h", test_name, $sampled(exp_out),
            $sampled({lhbl_dly, lvbl_dly, green, red, blue}));
        errors++;
    end

    din_a : assert property (@(posedge clk) rd_chk |-> (cpu_din == exp_din))
        checks++;
    else begin
        $display("[FAIL] %s expected %h actual %h", test_name, $sampled(exp_din),
            $sampled(cpu_din));
        errors++;
    end

    // whole-run limit
    initial begin
        #2000000;
        $display("simulation ran too long, stimulus never finished");
        $display("*** FAILED ***");
        $finish;
    end

    task automatic pal_write(logic [1:0] cs, logic [9:0] a, logic [15:0] d, logic [1:0] be);
        @(posedge clk);
        pal_cs   <= cs;
        cpu_addr <= a;
        cpu_dout <= d;
        dsn      <= be;
        if (cs[0] && !be[1]) gr_ref[a][15:8] = d[15:8];
        if (cs[0] && !be[0]) gr_ref[a][7:0] = d[7:0];
        if (cs[1] && !be[0]) b_ref[a] = d[7:0];
    endtask

    // address phase, data checked one clock later
    task automatic pal_read(logic [1:0] cs, logic [9:0] a);
        @(posedge clk);
        pal_cs   <= cs;
        cpu_addr <= a;
        dsn      <= 2'b11;
        @(posedge clk);
        pal_cs  <= 2'b00;
        rd_chk  <= 1'b1;
        exp_din <= cs[1] ? {8'hff, b_ref[a]} : gr_ref[a];
        @(posedge clk);
        rd_chk <= 1'b0;
    endtask

    // one pixel slot, inputs held two clocks past the sample edge
    task automatic run_slot(logic [7:0] b0, logic [7:0] b1, logic [7:0] b2,
            logic [7:0] ob, logic [2:0] ps, logic lh, logic lv);
        @(posedge clk);
        ba0_pxl <= b0;
        ba1_pxl <= b1;
        ba2_pxl <= b2;
        obj_pxl <= ob;
        prisel  <= ps;
        lhbl    <= lh;
        lvbl    <= lv;
        @(posedge clk);
        pxl_cen <= 1'b1;
        @(posedge clk);
        pxl_cen <= 1'b0;
        @(posedge clk);
    endtask

    task automatic random_slot(logic [2:0] ps, logic lh, logic lv);
        run_slot($random(seed), $random(seed), $random(seed), $random(seed), ps, lh, lv);
    endtask

    initial begin
        logic [9:0]  a;
        integer n;
        reset = 1'b1;
        pxl_cen = 1'b0;
        lhbl = 1'b0;
        lvbl = 1'b0;
        prisel = '0;
        ba0_pxl = '0;
        ba1_pxl = '0;
        ba2_pxl = '0;
        obj_pxl = '0;
        pal_cs = '0;
        cpu_addr = '0;
        cpu_dout = '0;
        dsn = 2'b11;
        prog_addr = '0;
        prom_din = '0;
        prom_we = 1'b0;
        check_on = 1'b0;
        rd_chk = 1'b0;
        exp_din = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        // outputs must sit blanked and black from here on
        check_on <= 1'b1;

        // prisel 0..3 are ranges of one code, 4..7 depend on every flag
        for (int i = 0; i < 1024; i++) begin
            a = i;
            @(posedge clk);
            prom_we   <= 1'b1;
            prog_addr <= a;
            prom_din  <= a[9] ? (a[6:5] ^ a[4:3] ^ a[2:1] ^ {a[0], a[0]}) : a[8:7];
            prom_ref[a] = a[9] ? (a[6:5] ^ a[4:3] ^ a[2:1] ^ {a[0], a[0]}) : a[8:7];
        end
        @(posedge clk);
        prom_we <= 1'b0;
        for (int i = 0; i < 1024; i++) begin
            a = i;
            pal_write(2'b01, a, (16'(i) * 16'h2f1b) ^ 16'hc35a, 2'b00);
            pal_write(2'b10, a, {8'h00, a[7:0] ^ {4{a[9:8]}} ^ 8'h96}, 2'b00);
        end
        pal_write(2'b00, '0, '0, 2'b11);

        test_name = "rg_palette";
        for (int i = 0; i < 8; i++) begin
            a = $random(seed);
            for (int be = 0; be < 4; be++) begin
                pal_write(2'b01, a, $random(seed), be[1:0]);
                pal_write(2'b00, a, '0, 2'b11);
                pal_read(2'b01, a);
            end
        end

        test_name = "blue_palette";
        for (int i = 0; i < 8; i++) begin
            a = $random(seed);
            pal_write(2'b10, a, $random(seed), 2'b00);
            pal_write(2'b00, a, '0, 2'b11);
            pal_read(2'b10, a);
            // upper lane alone leaves blue untouched
            pal_write(2'b10, a, $random(seed), 2'b01);
            pal_write(2'b00, a, '0, 2'b11);
            pal_read(2'b10, a);
        end

        test_name = "layer_select";
        n = 0;
        random_slot(3'd0, 1'b1, 1'b1);
        while (!(lhbl_dly && lvbl_dly) && n < 8) begin
            random_slot(3'd0, 1'b1, 1'b1);
            n++;
        end
        if (!(lhbl_dly && lvbl_dly)) begin
            $display("video never left blanking after slots started");
            errors++;
        end
        for (int ps = 0; ps < 4; ps++) begin
            repeat (12) random_slot(ps[2:0], 1'b1, 1'b1);
        end

        test_name = "priority_select";
        for (int ps = 0; ps < 8; ps++) begin
            repeat (3) run_slot(8'h35, 8'h8a, 8'h41, 8'hc7, ps[2:0], 1'b1, 1'b1);
        end

        test_name = "blanking";
        for (int i = 0; i < 24; i++) begin
            random_slot(3'd5, !(i % 5 == 2), !(i % 7 == 3 || i == 11));
        end

        test_name = "streaming";
        repeat (300) random_slot($random(seed), ($random(seed) & 15) != 0,
            ($random(seed) & 31) != 0);
        repeat (3) random_slot(3'd6, 1'b1, 1'b1);

        check_on <= 1'b0;
        @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* logic/blank_out.sv */
// ============================================================
// result stage
// delays colour and blanking by two pixel slots,
// forces black while either blanking signal is low
// ============================================================
`include "colmix_consts.svh"

module blank_out (
    input  logic            clk,
    input  logic            reset,
    input  logic            pxl_cen,
    input  logic            lhbl,
    input  logic            lvbl,
    input  video_pkg::rgb_t pal_rgb,
    output logic            lhbl_dly,
    output logic            lvbl_dly,
    output video_pkg::col_t red,
    output video_pkg::col_t green,
    output video_pkg::col_t blue
);

    // blanking history, bit 0 is the newest slot
    logic [`COLMIX_BLANK_DLY-1:0] lhbl_sr;
    logic [`COLMIX_BLANK_DLY-1:0] lvbl_sr;

    // palette colour of the previous slot
    video_pkg::rgb_t rgb_q;

    logic blank;

    // oldest blanking sample goes out with the colour
    assign blank = ~lhbl_sr[`COLMIX_BLANK_DLY-1] | ~lvbl_sr[`COLMIX_BLANK_DLY-1];

    // cleared to blanked so the screen starts dark
    always_ff @(posedge clk) begin
        if (reset) begin
            lhbl_sr <= '0;
            lvbl_sr <= '0;
        end else if (pxl_cen) begin
            lhbl_sr <= {lhbl_sr[`COLMIX_BLANK_DLY-2:0], lhbl};
            lvbl_sr <= {lvbl_sr[`COLMIX_BLANK_DLY-2:0], lvbl};
        end
    end

    // colour settles before the next slot, first stage
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            rgb_q <= pal_rgb;
        end
    end

    // output stage
    always_ff @(posedge clk) begin
        if (reset) begin
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else if (pxl_cen) begin
            lhbl_dly <= lhbl_sr[`COLMIX_BLANK_DLY-1];
            lvbl_dly <= lvbl_sr[`COLMIX_BLANK_DLY-1];
            // black during either blank
            red      <= blank ? '0 : rgb_q[15:8];
            green    <= blank ? '0 : rgb_q[23:16];
            blue     <= blank ? '0 : rgb_q[7:0];
        end
    end

    // lookup colour lands three clocks after a slot,
    // so the next slot may come no sooner than four clocks
    cen_spacing_a : assert property (@(posedge clk) disable iff (reset)
        pxl_cen |-> (!$past(pxl_cen) && !$past(pxl_cen, 2) && !$past(pxl_cen, 3)))
        else $error("blank_out: pixel slots closer than four clocks");

endmodule

/* logic/colmix.sv */
// ============================================================
// colour mixer top level
// layer priority decode, palette lookup and blanking stage
// ============================================================
`include "colmix_consts.svh"

module colmix (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        pxl_cen,
    // raw blanking, active low
    input  logic                        lhbl,
    input  logic                        lvbl,
    input  logic [`COLMIX_PRISEL_W-1:0] prisel,
    // layer pixels
    input  video_pkg::pxl_t             ba0_pxl,
    input  video_pkg::pxl_t             ba1_pxl,
    input  video_pkg::pxl_t             ba2_pxl,
    input  video_pkg::pxl_t             obj_pxl,
    // CPU palette port
    input  cpu_pkg::pal_cs_t            pal_cs,
    input  cpu_pkg::cpu_addr_t          cpu_addr,
    input  cpu_pkg::cpu_data_t          cpu_dout,
    input  cpu_pkg::cpu_be_t            dsn,
    output cpu_pkg::cpu_data_t          cpu_din,
    // priority PROM loading
    input  video_pkg::prio_addr_t       prog_addr,
    input  video_pkg::sel_t             prom_din,
    input  logic                        prom_we,
    // video out
    output video_pkg::col_t             red,
    output video_pkg::col_t             green,
    output video_pkg::col_t             blue,
    output logic                        lhbl_dly,
    output logic                        lvbl_dly
);

    // layer code, one clock after the slot
    video_pkg::sel_t sel;
    // palette colour, three clocks after the slot
    video_pkg::rgb_t pal_rgb;

    layer_prio layer_prio_inst (
        .clk       (clk),
        .reset     (reset),
        .pxl_cen   (pxl_cen),
        .prisel    (prisel),
        .ba0_pxl   (ba0_pxl),
        .ba1_pxl   (ba1_pxl),
        .ba2_pxl   (ba2_pxl),
        .obj_pxl   (obj_pxl),
        .prog_addr (prog_addr),
        .prom_din  (prom_din),
        .prom_we   (prom_we),
        .sel       (sel)
    );

    // pixels go in raw, the lookup aligns them with sel
    pal_lookup pal_lookup_inst (
        .clk      (clk),
        .reset    (reset),
        .sel      (sel),
        .ba0_pxl  (ba0_pxl),
        .ba1_pxl  (ba1_pxl),
        .ba2_pxl  (ba2_pxl),
        .obj_pxl  (obj_pxl),
        .pal_cs   (pal_cs),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .dsn      (dsn),
        .cpu_din  (cpu_din),
        .pal_rgb  (pal_rgb)
    );

    blank_out blank_out_inst (
        .clk      (clk),
        .reset    (reset),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .pal_rgb  (pal_rgb),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

endmodule

/* logic/colmix_consts.svh */
// ============================================================
// width and depth macros for the colour mixer
// pixel, palette, priority PROM and blank delay sizes
// ============================================================
`ifndef COLMIX_CONSTS_SVH
`define COLMIX_CONSTS_SVH

// one layer pixel, also the low part of a palette address
`define COLMIX_PXL_W     8
// palette word address, 1024 entries
`define COLMIX_PAL_AW    10
// priority PROM address, 1024 entries
`define COLMIX_PROM_AW   10
// layer code out of the PROM
`define COLMIX_SEL_W     2
// priority select written by the game
`define COLMIX_PRISEL_W  3
// result stage latency in pixel slots
`define COLMIX_BLANK_DLY 2

`endif

/* logic/cpu_pkg.sv */
// ============================================================
// CPU bus types of the palette port
// ============================================================
`include "colmix_consts.svh"

package cpu_pkg;

    // palette word address
    typedef logic [`COLMIX_PAL_AW-1:0] cpu_addr_t;

    // 16 bit bus word
    typedef logic [15:0] cpu_data_t;

    // byte lane strobes, active low, bit 1 is the upper byte
    typedef logic [1:0] cpu_be_t;

    // bit 0 red-green RAM, bit 1 blue RAM
    typedef logic [1:0] pal_cs_t;

endpackage

/* logic/layer_prio.sv */
// ============================================================
// layer priority decode
// builds the PROM address from layer flags and prisel,
// priority PROM with programming port and registered read
// ============================================================
`include "colmix_consts.svh"

module layer_prio (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        pxl_cen,
    input  logic [`COLMIX_PRISEL_W-1:0] prisel,
    input  video_pkg::pxl_t             ba0_pxl,
    input  video_pkg::pxl_t             ba1_pxl,
    input  video_pkg::pxl_t             ba2_pxl,
    input  video_pkg::pxl_t             obj_pxl,
    input  video_pkg::prio_addr_t       prog_addr,
    input  video_pkg::sel_t             prom_din,
    input  logic                        prom_we,
    output video_pkg::sel_t             sel
);

    // priority PROM, 1024 x 2
    video_pkg::sel_t prom [0:(1 << `COLMIX_PROM_AW)-1];

    // layer flags, "clear" means all zero
    logic ba0_clear;
    logic obj_clear;
    logic ba1_clear;
    logic ba2_clear;

    video_pkg::prio_addr_t next_addr;
    video_pkg::prio_addr_t prio_addr;

    // set by the first slot after reset
    logic prio_vld;

    assign ba0_clear = ~|ba0_pxl[3:0];
    assign obj_clear = ~|obj_pxl[3:0];
    // only the low three bits count for ba1
    assign ba1_clear = ~|ba1_pxl[2:0];
    // ba2 also needs its top bit low to count as clear
    assign ba2_clear = ~|{ba2_pxl[7], ba2_pxl[2:0]};

    // field order fixed by the PROM contents
    assign next_addr = {
        prisel,
        ba0_clear,
        obj_pxl[7],
        obj_clear,
        ba1_pxl[7],
        obj_pxl[3],
        ba1_clear,
        ba2_clear
    };

    // address sampled once per pixel slot
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            prio_addr <= next_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prio_vld <= 1'b0;
        end else if (pxl_cen) begin
            prio_vld <= 1'b1;
        end
    end

    // programming port
    always_ff @(posedge clk) begin
        if (prom_we) begin
            prom[prog_addr] <= prom_din;
        end
    end

    // read every clock, code lands one clock after the slot
    always_ff @(posedge clk) begin
        sel <= prom[prio_addr];
    end

    // PROM is loaded before video starts, so a sampled slot
    // must give a known layer code on the next clock
    sel_known_a : assert property (@(posedge clk) disable iff (reset)
        prio_vld |=> !$isunknown(sel))
        else $error("layer_prio: unknown layer code after slot sampled");

endmodule

/* logic/pal_lookup.sv */
// ============================================================
// palette lookup
// red-green RAM with byte strobes and blue RAM,
// CPU read/write port and video read through the layer mux
// ============================================================
`include "colmix_consts.svh"

module pal_lookup (
    input  logic                clk,
    input  logic                reset,
    input  video_pkg::sel_t     sel,
    input  video_pkg::pxl_t     ba0_pxl,
    input  video_pkg::pxl_t     ba1_pxl,
    input  video_pkg::pxl_t     ba2_pxl,
    input  video_pkg::pxl_t     obj_pxl,
    input  cpu_pkg::pal_cs_t    pal_cs,
    input  cpu_pkg::cpu_addr_t  cpu_addr,
    input  cpu_pkg::cpu_data_t  cpu_dout,
    input  cpu_pkg::cpu_be_t    dsn,
    output cpu_pkg::cpu_data_t  cpu_din,
    output video_pkg::rgb_t     pal_rgb
);

    // green in the upper byte, red in the lower byte
    cpu_pkg::cpu_data_t ram_gr [0:(1 << `COLMIX_PAL_AW)-1];
    video_pkg::col_t    ram_b  [0:(1 << `COLMIX_PAL_AW)-1];

    logic [1:0] we_gr;
    logic       we_b;

    // CPU read data
    cpu_pkg::cpu_data_t cpu_gr_q;
    video_pkg::col_t    cpu_b_q;
    logic               rd_blue;

    // layer pixels one clock behind the top inputs
    video_pkg::pxl_t ba0_q;
    video_pkg::pxl_t ba1_q;
    video_pkg::pxl_t ba2_q;
    video_pkg::pxl_t obj_q;
    video_pkg::pxl_t lyr_pxl;

    video_pkg::pal_addr_t pal_addr;

    // strobes are active low
    assign we_gr = ~dsn & {2{pal_cs[0]}};
    // blue sits on the lower lane only
    assign we_b  = ~dsn[0] & pal_cs[1];

    // CPU port, write lands on this clock, read data next clock
    always_ff @(posedge clk) begin
        if (we_gr[1]) begin
            ram_gr[cpu_addr][15:8] <= cpu_dout[15:8];
        end
        if (we_gr[0]) begin
            ram_gr[cpu_addr][7:0] <= cpu_dout[7:0];
        end
        if (we_b) begin
            ram_b[cpu_addr] <= cpu_dout[7:0];
        end
        cpu_gr_q <= ram_gr[cpu_addr];
        cpu_b_q  <= ram_b[cpu_addr];
    end

    // remember which RAM was addressed for the read mux
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_blue <= 1'b0;
        end else if (|pal_cs) begin
            rd_blue <= pal_cs[1];
        end
    end

    // blue reads back with the upper byte all ones
    assign cpu_din = rd_blue ? {8'hff, cpu_b_q} : cpu_gr_q;

    always_ff @(posedge clk) begin
        ba0_q <= ba0_pxl;
        ba1_q <= ba1_pxl;
        ba2_q <= ba2_pxl;
        obj_q <= obj_pxl;
    end

    // pick the pixel of the layer the code names
    always_comb begin
        case (sel)
            2'd0:    lyr_pxl = ba0_q;
            2'd1:    lyr_pxl = obj_q;
            2'd2:    lyr_pxl = ba1_q;
            default: lyr_pxl = ba2_q;
        endcase
    end

    // video port, address one clock after sel, colour one after that
    always_ff @(posedge clk) begin
        pal_addr <= {sel, lyr_pxl};
        pal_rgb  <= {ram_gr[pal_addr], ram_b[pal_addr]};
    end

    // CPU address decode is one-hot per access
    cs_excl_a : assert property (@(posedge clk) disable iff (reset)
        !(&pal_cs))
        else $error("pal_lookup: both palette chip selects active");

endmodule

/* logic/video_pkg.sv */
// ============================================================
// pixel side types of the colour mixer
// layer pixels, layer code, PROM and palette addresses, colour
// ============================================================
`include "colmix_consts.svh"

package video_pkg;

    // one layer pixel
    typedef logic [`COLMIX_PXL_W-1:0] pxl_t;

    // layer code from the priority PROM
    // 0 ba0, 1 obj, 2 ba1, 3 ba2
    typedef logic [`COLMIX_SEL_W-1:0] sel_t;

    // prisel on top, seven layer flags below
    typedef logic [`COLMIX_PROM_AW-1:0] prio_addr_t;

    // {layer code, pixel of that layer}
    typedef logic [`COLMIX_PAL_AW-1:0] pal_addr_t;

    // single colour channel
    typedef logic [7:0] col_t;

    // green in the top byte, red in the middle, blue at the bottom
    typedef logic [23:0] rgb_t;

endpackage
